/* compile.f */
+incdir+design
design/cache_addr_pkg.sv
design/cache_bus_pkg.sv
design/cache_ctrl.sv
design/burst_counter.sv
design/tag_store.sv
design/way_data_ram.sv
design/cache_top.sv
verification/sdram_model.sv
verification/cache_tb.sv

/* Makefile */
# Verilator build and run of the cache testbench.
# Any variable can be overridden, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "Simulation gave no result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/cache_tb.sv */
`include "cache_defs.svh"

module cache_tb;
    import cache_addr_pkg::*;

    localparam int     NUM_ENTRIES = 18;
    localparam int     RANDOM_OPS  = 200;
    localparam int     ACK_LIMIT   = 100;
    localparam logic   RD          = 1'b0;
    localparam logic   WR          = 1'b1;
    localparam tag_t   TAG_A       = 9'h011;
    localparam tag_t   TAG_B       = 9'h0A2;
    localparam tag_t   TAG_C       = 9'h1F3;
    localparam tag_t   NO_TAG      = 9'h000;
    localparam index_t SET_X       = 4'd2;
    localparam index_t SET_Y       = 4'd5;

    // Counts are SDRAM read bursts and write-back acks caused by the access.
    typedef struct packed {
        logic       is_write;
        tag_t       tag;
        index_t     index;
        word_sel_t  word;
        logic       hi;
        byte_t      data;
        logic [3:0] exp_reads;
        logic [3:0] exp_wb;
        tag_t       wb_tag;
    } op_entry_t;

    logic        sys_clk;
    logic        reset_n;
    dev_addr_t   address;
    byte_t       data_write;
    logic        read_req;
    logic        write_req;
    byte_t       data_read;
    logic        read_ack;
    logic        write_ack;
    sdram_addr_t sdram_address;
    word_t       sdram_data_write;
    word_t       sdram_data_read;
    logic        sdram_read_req;
    logic        sdram_write_req;
    logic        sdram_read_ack;
    logic        sdram_write_ack;

    op_entry_t   op_table [NUM_ENTRIES];
    byte_t       shadow [1 << `CACHE_ADDR_BITS];
    integer      seed;

    cache_top UUT (.*);

    sdram_model sdram (.*);

    initial sys_clk = 1'b0;
    always #5 sys_clk = ~sys_clk;

    function automatic dev_addr_t make_addr(tag_t tag, index_t index, word_sel_t word, logic hi);
        return {tag, index, word, hi};
    endfunction

    // Initial memory contents are the word address XOR a fixed pattern.
    function automatic byte_t pattern_byte(dev_addr_t addr);
        word_t w;
        w = word_t'(addr >> 1) ^ 16'hA5C3;
        return addr[0] ? w[15:8] : w[7:0];
    endfunction

    function automatic op_entry_t row(logic is_write, tag_t tag, index_t index, word_sel_t word,
                                      logic hi, byte_t data, int reads, int wb, tag_t wb_tag);
        return {is_write, tag, index, word, hi, data, 4'(reads), 4'(wb), wb_tag};
    endfunction

    function automatic tag_t pick_tag(logic [1:0] sel);
        case (sel)
            2'd0:    return TAG_A;
            2'd1:    return TAG_B;
            default: return TAG_C;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got %h, expected %h", name, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // ##############################
    // Device port access.
    // ##############################
    task automatic do_access(input logic is_write, input dev_addr_t addr, input byte_t wdata,
                             output int latency);
        int cycles;
        cycles = 0;
        @(posedge sys_clk);
        #1;
        address    = addr;
        data_write = wdata;
        read_req   = !is_write;
        write_req  = is_write;
        do begin
            @(posedge sys_clk);
            #1;
            cycles++;
        end while (!read_ack && !write_ack && cycles < ACK_LIMIT);
        if (!read_ack && !write_ack) begin
            $display("No ack from the cache within %0d cycles, address %h", ACK_LIMIT, addr);
            $display("TEST FAILED");
            $fatal(1, "missing ack");
        end else begin
            // First counted edge is the one that samples the request.
            latency = cycles - 1;
            check_value("read_ack", 32'(read_ack), 32'(!is_write));
            check_value("write_ack", 32'(write_ack), 32'(is_write));
            if (is_write) begin
                shadow[addr] = wdata;
            end else begin
                check_value("data_read", 32'(data_read), 32'(shadow[addr]));
            end
            @(posedge sys_clk);
            #1;
            read_req  = 1'b0;
            write_req = 1'b0;
            // Acks are single-cycle pulses.
            check_value("read_ack", 32'(read_ack), 32'd0);
            check_value("write_ack", 32'(write_ack), 32'd0);
        end
    endtask

    task automatic run_row(input op_entry_t e);
        dev_addr_t   addr;
        sdram_addr_t base;
        sdram_addr_t waddr;
        int          reads0;
        int          writes0;
        int          latency;
        int          i;
        addr    = make_addr(e.tag, e.index, e.word, e.hi);
        reads0  = sdram.read_count;
        writes0 = sdram.write_count;
        do_access(e.is_write, addr, e.data, latency);
        check_value("sdram_read_bursts", sdram.read_count - reads0, 32'(e.exp_reads));
        check_value("sdram_write_acks", sdram.write_count - writes0, 32'(e.exp_wb));
        if (e.exp_reads == 4'd0 && e.exp_wb == 4'd0) begin
            check_value("ack_latency", latency, 32'd3);
        end
        // The victim line goes out word by word, in order.
        base = sdram_addr_t'({e.wb_tag, e.index, 3'd0});
        for (i = 0; i < int'(e.exp_wb); i++) begin
            waddr = sdram.write_log[word_sel_t'(writes0 + i)];
            check_value("sdram_address", 32'(waddr), 32'(base + sdram_addr_t'(i)));
            // The written-back word matches the line as the device left it.
            check_value("sdram_data_write", 32'(sdram.mem[waddr[15:0]]),
                        32'({shadow[{waddr[15:0], 1'b1}], shadow[{waddr[15:0], 1'b0}]}));
        end
    endtask

    task automatic load_table();
        op_table[0]  = row(RD, TAG_A, SET_X, 3'd0, 1'b0, 8'h00, 1, 0, NO_TAG);
        op_table[1]  = row(RD, TAG_A, SET_X, 3'd5, 1'b1, 8'h00, 0, 0, NO_TAG);
        op_table[2]  = row(WR, TAG_A, SET_X, 3'd3, 1'b0, 8'h3C, 0, 0, NO_TAG);
        op_table[3]  = row(RD, TAG_A, SET_X, 3'd3, 1'b0, 8'h00, 0, 0, NO_TAG);
        // Partner byte keeps its old value.
        op_table[4]  = row(RD, TAG_A, SET_X, 3'd3, 1'b1, 8'h00, 0, 0, NO_TAG);
        op_table[5]  = row(RD, TAG_B, SET_X, 3'd1, 1'b0, 8'h00, 1, 0, NO_TAG);
        op_table[6]  = row(RD, TAG_A, SET_X, 3'd0, 1'b1, 8'h00, 0, 0, NO_TAG);
        // B is least recent, so C replaces it without a write-back.
        op_table[7]  = row(RD, TAG_C, SET_X, 3'd2, 1'b0, 8'h00, 1, 0, NO_TAG);
        op_table[8]  = row(RD, TAG_A, SET_X, 3'd1, 1'b0, 8'h00, 0, 0, NO_TAG);
        op_table[9]  = row(RD, TAG_B, SET_X, 3'd1, 1'b1, 8'h00, 1, 0, NO_TAG);
        // Dirty A goes out before C comes in.
        op_table[10] = row(RD, TAG_C, SET_X, 3'd4, 1'b0, 8'h00, 1, 8, TAG_A);
        op_table[11] = row(RD, TAG_A, SET_X, 3'd3, 1'b0, 8'h00, 1, 0, NO_TAG);
        op_table[12] = row(WR, TAG_A, SET_X, 3'd3, 1'b1, 8'hE7, 0, 0, NO_TAG);
        op_table[13] = row(RD, TAG_C, SET_Y, 3'd7, 1'b1, 8'h00, 1, 0, NO_TAG);
        op_table[14] = row(WR, TAG_C, SET_Y, 3'd7, 1'b0, 8'h11, 0, 0, NO_TAG);
        op_table[15] = row(RD, TAG_A, SET_Y, 3'd0, 1'b0, 8'h00, 1, 0, NO_TAG);
        op_table[16] = row(RD, TAG_B, SET_Y, 3'd6, 1'b0, 8'h00, 1, 8, TAG_C);
        op_table[17] = row(RD, TAG_C, SET_Y, 3'd7, 1'b0, 8'h00, 1, 0, NO_TAG);
    endtask

    // ##############################
    // Main sequence.
    // ##############################
    initial begin
        logic [31:0] r;
        dev_addr_t   addr;
        int          latency;
        int          n;
        seed        = 32'h9f507f98;
        reset_n     = 1'b0;
        address     = '0;
        data_write  = '0;
        read_req    = 1'b0;
        write_req   = 1'b0;
        for (n = 0; n < (1 << `CACHE_ADDR_BITS); n++) begin
            shadow[dev_addr_t'(n)] = pattern_byte(dev_addr_t'(n));
        end
        load_table();
        repeat (2) @(posedge sys_clk);
        #1;
        reset_n = 1'b1;
        check_value("read_ack", 32'(read_ack), 32'd0);
        check_value("write_ack", 32'(write_ack), 32'd0);
        check_value("sdram_read_req", 32'(sdram_read_req), 32'd0);
        check_value("sdram_write_req", 32'(sdram_write_req), 32'd0);

        for (n = 0; n < NUM_ENTRIES; n++) begin
            run_row(op_table[n]);
        end

        // Three tags over two sets keep both ways busy with conflicts.
        for (n = 0; n < RANDOM_OPS; n++) begin
            r    = $random(seed);
            addr = make_addr(pick_tag(r[9:8]), r[4] ? SET_X : SET_Y, r[7:5], r[1]);
            do_access(r[0], addr, r[23:16], latency);
        end

        $display("TEST PASSED");
        $finish;
    end

    initial begin
        repeat ((NUM_ENTRIES + RANDOM_OPS) * 100) @(posedge sys_clk);
        $display("Timeout: the run did not finish in %0d cycles",
                 (NUM_ENTRIES + RANDOM_OPS) * 100);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

/* verification/sdram_model.sv */
`include "cache_defs.svh"

module sdram_model (
    input  logic                        sys_clk,
    input  cache_addr_pkg::sdram_addr_t sdram_address,
    input  cache_addr_pkg::word_t       sdram_data_write,
    input  logic                        sdram_read_req,
    input  logic                        sdram_write_req,
    output cache_addr_pkg::word_t       sdram_data_read,
    output logic                        sdram_read_ack,
    output logic                        sdram_write_ack
);
    import cache_addr_pkg::*;

    word_t       mem [1 << 16];
    sdram_addr_t write_log [`BURST_LEN];
    sdram_addr_t base;
    int          read_count;
    int          write_count;
    logic        write_gap;

    // The model acts one time unit after each rising edge, once the requests have settled.
    initial begin
        for (int a = 0; a < (1 << 16); a++) begin
            mem[16'(a)] = word_t'(a) ^ 16'hA5C3;
        end
        sdram_data_read = '0;
        sdram_read_ack  = 1'b0;
        sdram_write_ack = 1'b0;
        read_count      = 0;
        write_count     = 0;
        write_gap       = 1'b0;
        forever begin
            @(posedge sys_clk);
            #1;
            sdram_write_ack = 1'b0;
            if (sdram_read_req) begin
                base = sdram_address;
                // Ack latency of 0 to 2 cycles.
                repeat (read_count % 3) begin
                    @(posedge sys_clk);
                    #1;
                end
                read_count++;
                sdram_read_ack = 1'b1;
                @(posedge sys_clk);
                #1;
                sdram_read_ack  = 1'b0;
                sdram_data_read = mem[base[15:0]];
                for (int i = 1; i < `BURST_LEN; i++) begin
                    @(posedge sys_clk);
                    #1;
                    sdram_data_read = mem[base[15:0] + 16'(i)];
                end
            end else if (sdram_write_req && !write_gap) begin
                mem[sdram_address[15:0]]             = sdram_data_write;
                write_log[word_sel_t'(write_count)] = sdram_address;
                write_count++;
                sdram_write_ack = 1'b1;
                write_gap       = 1'b1;
            end else begin
                // One idle cycle between write acks.
                write_gap = 1'b0;
            end
        end
    end

endmodule

/* design/cache_top.sv */
module cache_top (
    input  logic                        sys_clk,
    input  logic                        reset_n,
    input  cache_addr_pkg::dev_addr_t   address,
    input  cache_addr_pkg::byte_t       data_write,
    input  logic                        read_req,
    input  logic                        write_req,
    input  cache_addr_pkg::word_t       sdram_data_read,
    input  logic                        sdram_read_ack,
    input  logic                        sdram_write_ack,
    output cache_addr_pkg::byte_t       data_read,
    output logic                        read_ack,
    output logic                        write_ack,
    output cache_addr_pkg::sdram_addr_t sdram_address,
    output cache_addr_pkg::word_t       sdram_data_write,
    output logic                        sdram_read_req,
    output logic                        sdram_write_req
);
    import cache_addr_pkg::*;
    import cache_bus_pkg::*;

    // ##############################
    // Internal connections.
    // ##############################
    sdram_cmd_t sdram_cmd;
    lookup_t    lookup;
    index_t     look_index;
    tag_t       look_tag;
    logic       touch;
    logic       touch_way;
    logic       set_dirty;
    logic       fill_done;
    logic       fill_way;
    logic       clean;
    ram_addr_t  ram_addr;
    word_t      ram_wdata;
    byte_mask_t ram_mask;
    logic       ram_we0;
    logic       ram_we1;
    word_t      ram_q0;
    word_t      ram_q1;
    logic       burst_start;
    logic       burst_step;
    word_sel_t  burst_word;
    logic       burst_last;

    assign sdram_address    = sdram_cmd.address;
    assign sdram_data_write = sdram_cmd.wdata;
    assign sdram_read_req   = sdram_cmd.read_req;
    assign sdram_write_req  = sdram_cmd.write_req;

    cache_ctrl u_ctrl (.*);

    burst_counter u_burst (.*);

    tag_store u_tags (.*);

    way_data_ram u_ram (.*);

endmodule

/* design/way_data_ram.sv */
`include "cache_defs.svh"

module way_data_ram (
    input  logic                       sys_clk,
    input  cache_addr_pkg::ram_addr_t  ram_addr,
    input  cache_addr_pkg::word_t      ram_wdata,
    input  cache_addr_pkg::byte_mask_t ram_mask,
    input  logic                       ram_we0,
    input  logic                       ram_we1,
    output cache_addr_pkg::word_t      ram_q0,
    output cache_addr_pkg::word_t      ram_q1
);
    import cache_addr_pkg::*;

    localparam int WORDS = 1 << (`CACHE_INDEX_BITS + `CACHE_WORD_BITS);
    localparam int BYTES = `SDRAM_DATA_BITS / `DEV_DATA_BITS;
    localparam int BW    = `DEV_DATA_BITS;

    word_t      mem [2][WORDS];
    word_t      q   [2];
    logic [1:0] we;

    assign we = {ram_we1, ram_we0};

    // Both ways share the address.
    // Read data is registered and shows the old word on a write.
    always_ff @(posedge sys_clk) begin
        for (int w = 0; w < 2; w++) begin
            for (int b = 0; b < BYTES; b++) begin
                if (we[w] && ram_mask[b]) begin
                    mem[w][ram_addr][b*BW +: BW] <= ram_wdata[b*BW +: BW];
                end
            end
            q[w] <= mem[w][ram_addr];
        end
    end

    assign ram_q0 = q[0];
    assign ram_q1 = q[1];

endmodule

/* design/tag_store.sv */
`include "cache_defs.svh"

module tag_store (
    input  logic                   sys_clk,
    input  logic                   reset_n,
    input  cache_addr_pkg::index_t look_index,
    input  cache_addr_pkg::tag_t   look_tag,
    input  logic                   touch,
    input  logic                   touch_way,
    input  logic                   set_dirty,
    input  logic                   fill_done,
    input  logic                   fill_way,
    input  logic                   clean,
    output cache_bus_pkg::lookup_t lookup
);
    import cache_addr_pkg::*;
    import cache_bus_pkg::*;

    localparam int SETS = 1 << `CACHE_INDEX_BITS;

    tag_t            tags  [2][SETS];
    logic [1:0]      valid [SETS];
    logic [1:0]      dirty [SETS];
    // Per set, the way that was used least recently.
    logic [SETS-1:0] lru;

    logic [1:0] set_valid;
    logic [1:0] way_hit;
    logic       victim;

    // ##############################
    // Lookup.
    // ##############################
    always_comb begin
        set_valid = valid[look_index];
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = set_valid[w] && (tags[w][look_index] == look_tag);
        end

        // Empty way first, way 0 before way 1.
        if (!set_valid[0]) begin
            victim = 1'b0;
        end else if (!set_valid[1]) begin
            victim = 1'b1;
        end else begin
            victim = lru[look_index];
        end

        lookup.hit          = |way_hit;
        lookup.hit_way      = way_hit[1];
        lookup.victim_way   = victim;
        lookup.victim_dirty = dirty[look_index][victim];
        lookup.victim_tag   = tags[victim][look_index];
    end

    // ##############################
    // State updates.
    // ##############################
    always_ff @(posedge sys_clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int s = 0; s < SETS; s++) begin
                valid[s] <= '0;
                dirty[s] <= '0;
            end
            lru <= '0;
        end else begin
            if (touch) begin
                lru[look_index] <= ~touch_way;
            end
            if (set_dirty) begin
                dirty[look_index][touch_way] <= 1'b1;
            end
            if (clean) begin
                dirty[look_index][fill_way] <= 1'b0;
            end
            if (fill_done) begin
                valid[look_index][fill_way] <= 1'b1;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (fill_done) begin
            tags[fill_way][look_index] <= look_tag;
        end
    end

    // A fill only ever lands on a miss, so one set never holds a tag twice.
    assert property (@(posedge sys_clk) disable iff (!reset_n) !(&way_hit));

endmodule

/* design/burst_counter.sv */
`include "cache_defs.svh"

module burst_counter (
    input  logic                      sys_clk,
    input  logic                      reset_n,
    input  logic                      burst_start,
    input  logic                      burst_step,
    output cache_addr_pkg::word_sel_t burst_word,
    output logic                      burst_last
);
    import cache_addr_pkg::*;

    word_sel_t count;
    logic      active;

    // Active from start until the step past the last word.
    always_ff @(posedge sys_clk or negedge reset_n) begin
        if (!reset_n) begin
            count  <= '0;
            active <= 1'b0;
        end else if (burst_start) begin
            count  <= '0;
            active <= 1'b1;
        end else if (burst_step) begin
            count <= count + 1'b1;
            if (burst_last) begin
                active <= 1'b0;
            end
        end
    end

    assign burst_word = count;
    assign burst_last = (count == word_sel_t'(`BURST_LEN - 1));

    // The controller must not step a burst that has already finished.
    assert property (@(posedge sys_clk) disable iff (!reset_n)
        burst_step && !burst_start |-> active);

endmodule

/* design/cache_ctrl.sv */
module cache_ctrl (
    input  logic                       sys_clk,
    input  logic                       reset_n,
    input  cache_addr_pkg::dev_addr_t  address,
    input  cache_addr_pkg::byte_t      data_write,
    input  logic                       read_req,
    input  logic                       write_req,
    input  cache_bus_pkg::lookup_t     lookup,
    input  cache_addr_pkg::word_t      ram_q0,
    input  cache_addr_pkg::word_t      ram_q1,
    input  cache_addr_pkg::word_t      sdram_data_read,
    input  logic                       sdram_read_ack,
    input  logic                       sdram_write_ack,
    input  cache_addr_pkg::word_sel_t  burst_word,
    input  logic                       burst_last,
    output cache_addr_pkg::byte_t      data_read,
    output logic                       read_ack,
    output logic                       write_ack,
    output cache_bus_pkg::sdram_cmd_t  sdram_cmd,
    output cache_addr_pkg::index_t     look_index,
    output cache_addr_pkg::tag_t       look_tag,
    output logic                       touch_way,
    output logic                       touch,
    output logic                       set_dirty,
    output logic                       fill_done,
    output logic                       clean,
    output logic                       fill_way,
    output cache_addr_pkg::ram_addr_t  ram_addr,
    output cache_addr_pkg::word_t      ram_wdata,
    output cache_addr_pkg::byte_mask_t ram_mask,
    output logic                       ram_we0,
    output logic                       ram_we1,
    output logic                       burst_start,
    output logic                       burst_step
);
    import cache_addr_pkg::*;
    import cache_bus_pkg::*;

    typedef enum logic [3:0] {
        IDLE, LOOKUP, EVICT_WAIT, WRITE_BACK, FILL_REQ, FILL, RESUME, RAM_WAIT, RESPOND
    } state_t;

    state_t    state;
    state_t    next_state;
    dev_req_t  req;
    logic      way_sel;
    tag_t      victim_tag;
    word_t     rd_word;

    tag_t      req_tag;
    index_t    req_index;
    word_sel_t req_word;
    logic      req_hi;

    // Odd byte addresses live in the upper half of the word.
    assign {req_tag, req_index, req_word, req_hi} = req.addr;
    assign rd_word = way_sel ? ram_q1 : ram_q0;

    assign look_index = req_index;
    assign look_tag   = req_tag;
    assign touch_way  = lookup.hit_way;
    assign fill_way   = way_sel;

    // ############################
    // Next state and strobes.
    // ############################
    always_comb begin
        next_state  = state;
        touch       = 1'b0;
        set_dirty   = 1'b0;
        fill_done   = 1'b0;
        clean       = 1'b0;
        ram_addr    = {req_index, req_word};
        ram_wdata   = {req.wdata, req.wdata};
        ram_mask    = req_hi ? 2'b10 : 2'b01;
        ram_we0     = 1'b0;
        ram_we1     = 1'b0;
        burst_start = 1'b0;
        burst_step  = 1'b0;
        sdram_cmd.address   = sdram_addr_t'({req_tag, req_index, word_sel_t'(0)});
        sdram_cmd.wdata     = rd_word;
        sdram_cmd.read_req  = 1'b0;
        sdram_cmd.write_req = 1'b0;

        case (state)
            IDLE: begin
                if ((read_req || write_req) && !read_ack && !write_ack) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                if (lookup.hit) begin
                    touch = 1'b1;
                    // Byte write goes straight into the hit way.
                    if (req.is_write) begin
                        set_dirty = 1'b1;
                        ram_we0   = !lookup.hit_way;
                        ram_we1   = lookup.hit_way;
                    end
                    next_state = RAM_WAIT;
                end else begin
                    burst_start = 1'b1;
                    next_state  = lookup.victim_dirty ? EVICT_WAIT : FILL_REQ;
                end
            end
            EVICT_WAIT: begin
                // First victim word is fetched here.
                ram_addr   = {req_index, burst_word};
                next_state = WRITE_BACK;
            end
            WRITE_BACK: begin
                sdram_cmd.write_req = 1'b1;
                sdram_cmd.address   = sdram_addr_t'({victim_tag, req_index, burst_word});
                burst_step          = sdram_write_ack;
                // Look one word ahead on an ack so the data is ready next cycle.
                ram_addr = {req_index, burst_word + word_sel_t'(sdram_write_ack)};
                if (sdram_write_ack && burst_last) begin
                    clean      = 1'b1;
                    next_state = FILL_REQ;
                end
            end
            FILL_REQ: begin
                sdram_cmd.read_req = 1'b1;
                if (sdram_read_ack) begin
                    burst_start = 1'b1;
                    next_state  = FILL;
                end
            end
            FILL: begin
                ram_addr   = {req_index, burst_word};
                ram_wdata  = sdram_data_read;
                ram_mask   = 2'b11;
                ram_we0    = !way_sel;
                ram_we1    = way_sel;
                burst_step = 1'b1;
                if (burst_last) begin
                    fill_done  = 1'b1;
                    clean      = 1'b1;
                    next_state = RESUME;
                end
            end
            RESUME:   next_state = LOOKUP;
            RAM_WAIT: next_state = RESPOND;
            RESPOND:  next_state = IDLE;
            default:  next_state = IDLE;
        endcase
    end

    // ############################
    // State and handshake registers.
    // ############################
    always_ff @(posedge sys_clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= IDLE;
            read_ack  <= 1'b0;
            write_ack <= 1'b0;
        end else begin
            state     <= next_state;
            read_ack  <= (state == RESPOND) && !req.is_write;
            write_ack <= (state == RESPOND) && req.is_write;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (state == IDLE && next_state == LOOKUP) begin
            req.addr     <= address;
            req.wdata    <= data_write;
            req.is_write <= write_req;
        end
        // Hit way for the response, victim way for the refill.
        if (state == LOOKUP) begin
            way_sel    <= lookup.hit ? lookup.hit_way : lookup.victim_way;
            victim_tag <= lookup.victim_tag;
        end
        if (state == RESPOND && !req.is_write) begin
            data_read <= req_hi ? rd_word[15:8] : rd_word[7:0];
        end
    end

    assert property (@(posedge sys_clk) disable iff (!reset_n) !(read_ack && write_ack));

    assert property (@(posedge sys_clk) disable iff (!reset_n)
        !(sdram_cmd.read_req && sdram_cmd.write_req));

endmodule

/* design/cache_bus_pkg.sv */
package cache_bus_pkg;

    import cache_addr_pkg::*;

    // Device request as latched at accept time.
    typedef struct packed {
        dev_addr_t addr;
        byte_t     wdata;
        logic      is_write;
    } dev_req_t;

    // SDRAM command bundle.
    // Address and data are only meaningful while a request is up.
    typedef struct packed {
        sdram_addr_t address;
        word_t       wdata;
        logic        read_req;
        logic        write_req;
    } sdram_cmd_t;

    // Tag store answer for the set and tag under lookup.
    typedef struct packed {
        logic hit;
        logic hit_way;
        logic victim_way;
        logic victim_dirty;
        tag_t victim_tag;
    } lookup_t;

endpackage

/* design/cache_addr_pkg.sv */
`include "cache_defs.svh"

package cache_addr_pkg;

    // Device byte address, split as tag | index | word | byte.
    typedef logic [`CACHE_ADDR_BITS-1:0] dev_addr_t;

    typedef logic [`CACHE_ADDR_BITS-`CACHE_INDEX_BITS-`CACHE_WORD_BITS-2:0] tag_t;
    typedef logic [`CACHE_INDEX_BITS-1:0] index_t;
    typedef logic [`CACHE_WORD_BITS-1:0] word_sel_t;

    // Data RAM address, index then word.
    typedef logic [`CACHE_INDEX_BITS+`CACHE_WORD_BITS-1:0] ram_addr_t;

    typedef logic [`SDRAM_ADDR_BITS-1:0] sdram_addr_t;

    // Data widths.
    typedef logic [`DEV_DATA_BITS-1:0] byte_t;
    typedef logic [`SDRAM_DATA_BITS-1:0] word_t;
    typedef logic [`SDRAM_DATA_BITS/`DEV_DATA_BITS-1:0] byte_mask_t;

endpackage

/* design/cache_defs.svh */
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// Cache geometry.
// 16 sets of 8 words, two ways.
`define CACHE_INDEX_BITS 4
`define CACHE_WORD_BITS  3
`define BURST_LEN        8

// Device side, byte addressed.
`define CACHE_ADDR_BITS  17
`define DEV_DATA_BITS    8

// SDRAM side, word addressed.
`define SDRAM_ADDR_BITS  24
`define SDRAM_DATA_BITS  16

`endif
